// File: vlog.f
+incdir+rtl
rtl/switch_pkg.sv
rtl/switch_if.sv
rtl/cdc_fifo.sv
rtl/ingress_port.sv
rtl/voq_switch.sv
rtl/egress_port.sv
rtl/top_nxn.sv
tb/clk_gen.sv
tb/tb_top_nxn.sv

// File: run_sim.sh
#!/bin/sh
# build and run the switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top_nxn -f vlog.f

./obj_dir/Vtb_top_nxn | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "run_sim: PASS"
else
    echo "run_sim: FAIL"
    exit 1
fi

// File: tb/tb_top_nxn.sv
`include "switch_params.svh"

module tb_top_nxn;

    localparam int N  = `PORT_NUB_TOTAL;
    localparam int DW = `DATA_WIDTH;
    localparam int FW = DW + 2;
    localparam int PW = $clog2(N);
    // packets over all tests, 4 + 12 + 16 + 40
    localparam int PKTS     = 72;
    localparam int WD_LIMIT = PKTS * 200 + 2000;
    // external cycles allowed for the outputs to empty after a test
    localparam int DRAIN_LIMIT = 1000;

    logic            internal_clk;
    logic            external_clk;
    logic            rst_n;
    logic [N-1:0]    wr_sop;
    logic [N-1:0]    wr_eop;
    logic [N-1:0]    wr_vld;
    logic [N*DW-1:0] wr_data;
    logic [N-1:0]    rd_sop;
    logic [N-1:0]    rd_eop;
    logic [N-1:0]    rd_vld;
    logic [N*DW-1:0] rd_data;
    logic [N-1:0]    ready;
    logic            full;
    logic            alm_ost_full;

    int              errors;
    int              pending;
    int              tests_ok;
    int              tests_bad;
    logic            senders_done;
    logic [N-1:0]    in_pkt;
    // expected words, indexed src * N + dst
    logic [FW-1:0]   exp_q [N*N][$];
    int              plan_dst [N][$];
    int              plan_len [N][$];

    clk_gen #(.PERIOD(10)) ext_clk_gen (.clk(external_clk));
    clk_gen #(.PERIOD(7))  int_clk_gen (.clk(internal_clk));

    top_nxn dut0 (
        .internal_clk (internal_clk),
        .external_clk (external_clk),
        .rst_n        (rst_n),
        .wr_sop       (wr_sop),
        .wr_eop       (wr_eop),
        .wr_vld       (wr_vld),
        .wr_data      (wr_data),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data),
        .ready        (ready),
        .full         (full),
        .alm_ost_full (alm_ost_full)
    );

    // ********************
    // scoreboard
    // ********************

    task automatic check_word(input int qi, input logic [FW-1:0] got, input int port);
        logic [FW-1:0] exp;
        assert (exp_q[qi].size() > 0) else begin
            $display("FAIL %0t: port %0d got %h with nothing expected from source %0d",
                     $time, port, got, qi / N);
            errors++;
        end
        if (exp_q[qi].size() > 0) begin
            exp = exp_q[qi].pop_front();
            pending--;
            assert (got == exp) else begin
                $display("FAIL %0t: port %0d got %h, expected %h", $time, port, got, exp);
                errors++;
            end
        end
    endtask

    // open packet per output, for the sop check
    always @(posedge external_clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt <= '0;
        end else begin
            for (int p = 0; p < N; p++) begin
                if (rd_vld[p] && ready[p]) begin
                    in_pkt[p] <= rd_sop[p] ? !rd_eop[p] : (in_pkt[p] && !rd_eop[p]);
                end
            end
        end
    end

    // a full queue is always past the almost-full level
    assert property (@(posedge external_clk) disable iff (!rst_n) full |-> alm_ost_full)
    else begin
        $display("FAIL %0t: full high while alm_ost_full is low", $time);
        errors++;
    end

    for (genvar p = 0; p < N; p++) begin : g_port
        logic [FW-1:0] hdr;
        logic          have_hdr;
        logic          in_body;
        int            qi;

        assert property (@(posedge external_clk) disable iff (!rst_n)
            rd_vld[p] && !ready[p] |=> rd_vld[p] && $stable(rd_data[p*DW +: DW])
                && $stable(rd_sop[p]) && $stable(rd_eop[p]))
        else begin
            $display("FAIL %0t: port %0d output moved while stalled", $time, p);
            errors++;
        end

        assert property (@(posedge external_clk) disable iff (!rst_n)
            rd_vld[p] && ready[p] && rd_sop[p] |-> !in_pkt[p])
        else begin
            $display("FAIL %0t: port %0d sop inside an open packet", $time, p);
            errors++;
        end

        // outputs settle on the rising edge, sample on the falling one
        always @(negedge external_clk) begin
            logic [FW-1:0] beat;
            beat = {rd_sop[p], rd_eop[p], rd_data[p*DW +: DW]};
            if (!rst_n) begin
                have_hdr = 1'b0;
                in_body  = 1'b0;
            end else if (rd_vld[p] && ready[p]) begin
                if (beat[FW-1]) begin
                    hdr      = beat;
                    have_hdr = 1'b1;
                    in_body  = 1'b0;
                end else if (have_hdr) begin
                    // payload word 1 names the source
                    qi       = int'(beat[PW-1:0]) * N + p;
                    have_hdr = 1'b0;
                    in_body  = !beat[FW-2];
                    check_word(qi, hdr, p);
                    check_word(qi, beat, p);
                end else begin
                    assert (in_body) else begin
                        $display("FAIL %0t: port %0d word outside any packet", $time, p);
                        errors++;
                    end
                    if (in_body) begin
                        in_body = !beat[FW-2];
                        check_word(qi, beat, p);
                    end
                end
            end
        end
    end

    // ********************
    // stimulus
    // ********************

    // called 1 unit after a rising edge, returns at the same phase
    task automatic send_packet(input int port, input int dst, input int len);
        logic [DW-1:0] word;
        // pause only between packets so an open packet always completes
        while (alm_ost_full) begin
            @(posedge external_clk);
            #1;
        end
        for (int w = 0; w < len; w++) begin
            word = DW'($urandom);
            if (w == 0) begin
                word[PW-1:0] = dst[PW-1:0];
            end
            if (w == 1) begin
                word[PW-1:0] = port[PW-1:0];
            end
            wr_sop[port]           = (w == 0);
            wr_eop[port]           = (w == len - 1);
            wr_vld[port]           = 1'b1;
            wr_data[port*DW +: DW] = word;
            exp_q[port*N + dst].push_back({wr_sop[port], wr_eop[port], word});
            pending++;
            @(posedge external_clk);
            #1;
        end
        wr_vld[port] = 1'b0;
        wr_sop[port] = 1'b0;
        wr_eop[port] = 1'b0;
    endtask

    task automatic run_all_ports();
        for (int p = 0; p < N; p++) begin
            automatic int pp = p;
            fork
                while (plan_dst[pp].size() > 0) begin
                    send_packet(pp, plan_dst[pp].pop_front(), plan_len[pp].pop_front());
                end
            join_none
        end
        wait fork;
    endtask

    // wait for every expected word, then flag and flush whatever is left
    task automatic drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(posedge external_clk);
            waited++;
        end
        repeat (4) @(posedge external_clk);
        #1;
        for (int q = 0; q < N * N; q++) begin
            assert (exp_q[q].size() == 0) else begin
                $display("scoreboard queue %0d still holds %0d words", q, exp_q[q].size());
                errors++;
            end
            exp_q[q].delete();
        end
        pending = 0;
    endtask

    task automatic end_test(input string name, input int mark);
        if (errors == mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        repeat (WD_LIMIT) @(posedge external_clk);
        $display("watchdog: run timed out after %0d external cycles", WD_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          mark;
        int          n;
        void'($urandom(32'h0a377d97));
        rst_n        = 1'b0;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_vld       = '0;
        wr_data      = '0;
        ready        = '1;
        errors       = 0;
        pending      = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        senders_done = 1'b0;
        repeat (16) @(posedge external_clk);
        #1;
        rst_n = 1'b1;

        mark = errors;
        repeat (40) begin
            @(negedge external_clk);
            assert (rd_vld == '0 && !full && !alm_ost_full) else begin
                $display("FAIL %0t: outputs active with no traffic", $time);
                errors++;
            end
        end
        @(posedge external_clk);
        #1;
        end_test("idle after reset", mark);

        mark = errors;
        for (int p = 0; p < N; p++) begin
            plan_dst[p].push_back((p + 1) % N);
            plan_len[p].push_back(4);
        end
        run_all_ports();
        drain();
        end_test("single packets", mark);

        mark = errors;
        for (int p = 0; p < N; p++) begin
            for (int k = 0; k < 3; k++) begin
                plan_dst[p].push_back(0);
                plan_len[p].push_back(4);
            end
        end
        run_all_ports();
        drain();
        end_test("contention on port 0", mark);

        // port 2 stalled until its queues report full
        mark = errors;
        for (int p = 0; p < N; p++) begin
            for (int k = 0; k < 4; k++) begin
                plan_dst[p].push_back(2);
                plan_len[p].push_back(4);
            end
        end
        ready[2] = 1'b0;
        fork
            run_all_ports();
            begin
                n = 0;
                while (!alm_ost_full && n < 2000) begin
                    @(posedge external_clk);
                    n++;
                end
                assert (alm_ost_full) else begin
                    $display("alm_ost_full never rose with port 2 stalled");
                    errors++;
                end
                n = 0;
                while (!full && n < 2000) begin
                    @(posedge external_clk);
                    n++;
                end
                assert (full) else begin
                    $display("full never rose with port 2 stalled");
                    errors++;
                end
                repeat (20) @(posedge external_clk);
                #1;
                ready[2] = 1'b1;
            end
        join
        drain();
        end_test("back-pressure on port 2", mark);

        mark = errors;
        for (int k = 0; k < 40; k++) begin
            plan_dst[k % N].push_back(int'($urandom_range(N - 1, 0)));
            plan_len[k % N].push_back(int'($urandom_range(6, 2)));
        end
        fork
            begin
                run_all_ports();
                senders_done = 1'b1;
            end
            while (!senders_done) begin
                ready = N'($urandom);
                @(posedge external_clk);
                #1;
            end
        join
        ready = '1;
        drain();
        end_test("random traffic", mark);

        $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk
);

    // odd periods put the extra unit in the low phase
    localparam int HIGH = PERIOD / 2;
    localparam int LOW  = PERIOD - HIGH;

    initial begin
        clk = 1'b0;
        forever begin
            #LOW clk = 1'b1;
            #HIGH clk = 1'b0;
        end
    end

endmodule

// File: rtl/top_nxn.sv
`include "switch_params.svh"

module top_nxn (
    input  logic                                     internal_clk,
    input  logic                                     external_clk,
    input  logic                                     rst_n,

    input  logic [`PORT_NUB_TOTAL-1:0]               wr_sop,
    input  logic [`PORT_NUB_TOTAL-1:0]               wr_eop,
    input  logic [`PORT_NUB_TOTAL-1:0]               wr_vld,
    input  logic [`PORT_NUB_TOTAL*`DATA_WIDTH-1:0]   wr_data,

    output logic [`PORT_NUB_TOTAL-1:0]               rd_sop,
    output logic [`PORT_NUB_TOTAL-1:0]               rd_eop,
    output logic [`PORT_NUB_TOTAL-1:0]               rd_vld,
    output logic [`PORT_NUB_TOTAL*`DATA_WIDTH-1:0]   rd_data,
    input  logic [`PORT_NUB_TOTAL-1:0]               ready,
    output logic                                     full,
    output logic                                     alm_ost_full
);

    localparam int N  = `PORT_NUB_TOTAL;
    localparam int DW = `DATA_WIDTH;

    ingress_if in_bus [N] ();
    egress_if  out_bus [N] ();

    logic [N-1:0] in_alm_full;
    logic         core_alm;

    voq_switch u_voq (
        .clk          (internal_clk),
        .rst_n        (rst_n),
        .in_ports     (in_bus),
        .out_ports    (out_bus),
        .full         (full),
        .alm_ost_full (core_alm)
    );

    // ********************
    // port pairs
    // ********************

    for (genvar i = 0; i < N; i++) begin : g_port
        ingress_port u_in (
            .external_clk (external_clk),
            .internal_clk (internal_clk),
            .rst_n        (rst_n),
            .wr_sop       (wr_sop[i]),
            .wr_eop       (wr_eop[i]),
            .wr_vld       (wr_vld[i]),
            .wr_data      (wr_data[i*DW +: DW]),
            .alm_full     (in_alm_full[i]),
            .port_o       (in_bus[i])
        );

        egress_port u_out (
            .internal_clk (internal_clk),
            .external_clk (external_clk),
            .rst_n        (rst_n),
            .port_i       (out_bus[i]),
            .ready        (ready[i]),
            .rd_sop       (rd_sop[i]),
            .rd_eop       (rd_eop[i]),
            .rd_vld       (rd_vld[i]),
            .rd_data      (rd_data[i*DW +: DW])
        );
    end

    // senders back off on any queue or ingress fifo filling
    assign alm_ost_full = core_alm | (|in_alm_full);

endmodule

// File: rtl/egress_port.sv
`include "switch_params.svh"

module egress_port (
    input  logic                   internal_clk,
    input  logic                   external_clk,
    input  logic                   rst_n,
    egress_if.egress               port_i,
    input  logic                   ready,
    output logic                   rd_sop,
    output logic                   rd_eop,
    output logic                   rd_vld,
    output logic [`DATA_WIDTH-1:0] rd_data
);

    import switch_pkg::*;

    localparam int N = `PORT_NUB_TOTAL;

    egress_state_t state;
    port_id_t      sel;
    port_id_t      last;
    port_id_t      pick;
    logic          found;
    logic          fifo_full;
    logic          fifo_empty;
    flit_t         out_flit;

    // ********************
    // round-robin pick
    // ********************

    // first non-empty source after the last one served
    always_comb begin
        port_id_t idx;
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= N; k++) begin
            idx = port_id_t'(last + k);
            if (!found && !port_i.empty[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EG_IDLE;
            sel   <= '0;
            last  <= '1;
        end else begin
            case (state)
                EG_IDLE: begin
                    if (found) begin
                        sel   <= pick;
                        state <= EG_XFER;
                    end
                end
                EG_XFER: begin
                    if (port_i.rd_en && port_i.flit.eop) begin
                        last  <= sel;
                        state <= EG_IDLE;
                    end
                end
                default: state <= EG_IDLE;
            endcase
        end
    end

    // stall on a full crossing fifo or a packet still arriving
    assign port_i.rd_sel = sel;
    assign port_i.rd_en  = (state == EG_XFER) & ~fifo_full & ~port_i.empty[sel];

    cdc_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (`CDC_DEPTH)
    ) u_cdc (
        .wr_clk   (internal_clk),
        .rst_n    (rst_n),
        .wr_en    (port_i.rd_en),
        .wr_flit  (port_i.flit),
        .wr_full  (fifo_full),
        .rd_clk   (external_clk),
        .rd_en    (rd_vld & ready),
        .rd_flit  (out_flit),
        .rd_empty (fifo_empty)
    );

    // external side shows the fifo head
    assign rd_vld  = ~fifo_empty;
    assign rd_sop  = out_flit.sop;
    assign rd_eop  = out_flit.eop;
    assign rd_data = out_flit.data;

endmodule

// File: rtl/voq_switch.sv
`include "switch_params.svh"

module voq_switch (
    input  logic  clk,
    input  logic  rst_n,
    ingress_if.sw in_ports [`PORT_NUB_TOTAL],
    egress_if.sw  out_ports [`PORT_NUB_TOTAL],
    output logic  full,
    output logic  alm_ost_full
);

    import switch_pkg::*;

    localparam int N  = `PORT_NUB_TOTAL;
    localparam int AW = $clog2(`VOQ_DEPTH);
    localparam int CW = AW + 1;

    localparam logic [CW-1:0] CNT_FULL = CW'(`VOQ_DEPTH);
    localparam logic [CW-1:0] CNT_ALM  = CW'(`VOQ_DEPTH - `VOQ_ALM_MARGIN);

    // head of every queue, [src][dst]
    flit_t                head [N][N];
    // room per queue, [src][dst]
    logic [N-1:0][N-1:0]  room;
    // empty per output column, [dst][src]
    logic [N-1:0][N-1:0]  col_empty;
    logic [N*N-1:0]       q_full;
    logic [N*N-1:0]       q_alm;

    // ********************
    // queue array
    // ********************

    for (genvar s = 0; s < N; s++) begin : g_src
        for (genvar d = 0; d < N; d++) begin : g_dst
            flit_t         mem [`VOQ_DEPTH];
            logic [AW-1:0] wr_ptr;
            logic [AW-1:0] rd_ptr;
            logic [CW-1:0] cnt;
            logic          push;
            logic          pop;

            assign push = in_ports[s].vld & in_ports[s].ready
                        & (in_ports[s].tx == port_id_t'(d));
            assign pop  = out_ports[d].rd_en & (out_ports[d].rd_sel == port_id_t'(s))
                        & (cnt != '0);

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    cnt    <= '0;
                end else begin
                    if (push) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (pop) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    case ({push, pop})
                        2'b10:   cnt <= cnt + 1'b1;
                        2'b01:   cnt <= cnt - 1'b1;
                        default: cnt <= cnt;
                    endcase
                end
            end

            always_ff @(posedge clk) begin
                if (push) begin
                    mem[wr_ptr] <= in_ports[s].flit;
                end
            end

            assign head[s][d]      = mem[rd_ptr];
            assign room[s][d]      = (cnt != CNT_FULL);
            assign col_empty[d][s] = (cnt == '0);
            assign q_full[s*N+d]   = (cnt == CNT_FULL);
            assign q_alm[s*N+d]    = (cnt >= CNT_ALM);
        end

        // room only toward the queue the current word targets
        assign in_ports[s].ready = room[s][in_ports[s].tx];
    end

    for (genvar d = 0; d < N; d++) begin : g_out
        assign out_ports[d].empty = col_empty[d];
        assign out_ports[d].flit  = head[out_ports[d].rd_sel][d];
    end

    assign full         = |q_full;
    assign alm_ost_full = |q_alm;

endmodule

// File: rtl/ingress_port.sv
`include "switch_params.svh"

module ingress_port (
    input  logic                   external_clk,
    input  logic                   internal_clk,
    input  logic                   rst_n,
    input  logic                   wr_sop,
    input  logic                   wr_eop,
    input  logic                   wr_vld,
    input  logic [`DATA_WIDTH-1:0] wr_data,
    output logic                   alm_full,
    ingress_if.ingress             port_o
);

    import switch_pkg::*;

    flit_t          wr_flit;
    flit_t          rd_flit;
    logic           fifo_full;
    logic           fifo_empty;
    logic           pop;
    ingress_state_t state;
    port_id_t       tx_q;
    port_id_t       hdr_dest;

    assign wr_flit = '{sop: wr_sop, eop: wr_eop, data: wr_data};

    cdc_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (`CDC_DEPTH)
    ) u_cdc (
        .wr_clk   (external_clk),
        .rst_n    (rst_n),
        .wr_en    (wr_vld),
        .wr_flit  (wr_flit),
        .wr_full  (fifo_full),
        .rd_clk   (internal_clk),
        .rd_en    (pop),
        .rd_flit  (rd_flit),
        .rd_empty (fifo_empty)
    );

    // sender-side level, any word beyond this is lost
    assign alm_full = fifo_full;

    // ********************
    // internal side
    // ********************

    assign hdr_dest    = rd_flit.data[PORT_W-1:0];
    assign port_o.vld  = ~fifo_empty;
    assign port_o.flit = rd_flit;
    assign port_o.tx   = (state == IN_HDR) ? hdr_dest : tx_q;
    assign pop         = port_o.vld & port_o.ready;

    always_ff @(posedge internal_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IN_HDR;
            tx_q  <= '0;
        end else if (pop) begin
            if (state == IN_HDR) begin
                tx_q <= hdr_dest;
                // single-word packet stays in header state
                if (!rd_flit.eop) begin
                    state <= IN_BODY;
                end
            end else if (rd_flit.eop) begin
                state <= IN_HDR;
            end
        end
    end

endmodule

// File: rtl/cdc_fifo.sv
module cdc_fifo #(
    parameter int WIDTH = 18,
    parameter int DEPTH = 16
) (
    input  logic             wr_clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_flit,
    output logic             wr_full,

    input  logic             rd_clk,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_flit,
    output logic             rd_empty
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];

    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_nxt;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_nxt;
    logic [AW:0] rd_gray;

    // opposite-domain pointers, two flops each
    logic [AW:0] rd_gray_m;
    logic [AW:0] rd_gray_s;
    logic [AW:0] wr_gray_m;
    logic [AW:0] wr_gray_s;

    logic        wr_fire;
    logic        rd_fire;

    // ********************
    // write domain
    // ********************

    assign wr_fire    = wr_en & ~wr_full;
    assign wr_bin_nxt = wr_bin + {{AW{1'b0}}, wr_fire};

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin    <= '0;
            wr_gray   <= '0;
            rd_gray_m <= '0;
            rd_gray_s <= '0;
        end else begin
            wr_bin    <= wr_bin_nxt;
            wr_gray   <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            rd_gray_m <= rd_gray;
            rd_gray_s <= rd_gray_m;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[AW-1:0]] <= wr_flit;
        end
    end

    // full when the top two gray bits differ and the rest match
    assign wr_full = (wr_gray == {~rd_gray_s[AW:AW-1], rd_gray_s[AW-2:0]});

    // ********************
    // read domain
    // ********************

    assign rd_fire    = rd_en & ~rd_empty;
    assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_fire};

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            wr_gray_m <= '0;
            wr_gray_s <= '0;
        end else begin
            rd_bin    <= rd_bin_nxt;
            rd_gray   <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            wr_gray_m <= wr_gray;
            wr_gray_s <= wr_gray_m;
        end
    end

    assign rd_empty = (rd_gray == wr_gray_s);
    assign rd_flit  = mem[rd_bin[AW-1:0]];

endmodule

// File: rtl/switch_if.sv
`include "switch_params.svh"

// ingress side to switch core, one per source port
interface ingress_if;
    import switch_pkg::*;

    logic     vld;
    flit_t    flit;
    port_id_t tx;
    logic     ready;

    modport ingress (output vld, output flit, output tx, input ready);
    modport sw (input vld, input flit, input tx, output ready);

endinterface

// switch core to egress side, one per output port
interface egress_if;
    import switch_pkg::*;

    // one bit per source queue in this column
    logic [`PORT_NUB_TOTAL-1:0] empty;
    logic                       rd_en;
    port_id_t                   rd_sel;
    flit_t                      flit;

    modport sw (output empty, output flit, input rd_en, input rd_sel);
    modport egress (input empty, input flit, output rd_en, output rd_sel);

endinterface

// File: rtl/switch_pkg.sv
`include "switch_params.svh"

package switch_pkg;

    localparam int PORT_W = $clog2(`PORT_NUB_TOTAL);

    typedef logic [PORT_W-1:0] port_id_t;

    // one word of a packet as stored in every fifo and queue
    typedef struct packed {
        logic                   sop;
        logic                   eop;
        logic [`DATA_WIDTH-1:0] data;
    } flit_t;

    typedef enum logic {
        IN_HDR,
        IN_BODY
    } ingress_state_t;

    typedef enum logic {
        EG_IDLE,
        EG_XFER
    } egress_state_t;

endpackage

// File: rtl/switch_params.svh
`ifndef SWITCH_PARAMS_SVH
`define SWITCH_PARAMS_SVH

// ********************
// switch dimensions
// ********************

`define PORT_NUB_TOTAL  4
`define DATA_WIDTH      16

// queue depths in words
`define VOQ_DEPTH       8
`define VOQ_ALM_MARGIN  2

// crossing fifos, both directions
`define CDC_DEPTH       16

`endif
